/* Bender.yml */
package:
  name: icache_fetch

sources:
  - files:
      - logic/cache_pkg.sv
      - logic/mem_pkg.sv
      - logic/data_array.sv
      - logic/meta_array.sv
      - logic/i_cache.sv
      - logic/fill_counter.sv
      - logic/fill_fsm.sv
      - logic/main_memory.sv
      - logic/icache_top.sv
  - target: test
    files:
      - verification/icache_tb.sv

/* logic/cache_pkg.sv */
package cache_pkg;

    localparam int tag_bits = 6;
    localparam int index_bits = 6;
    localparam int offset_bits = 4;

    localparam int num_sets = 1 << index_bits;
    localparam int num_blocks = 2 * num_sets;  // set i way w lives in block 2i+w
    localparam int words_per_block = 8;

    localparam int meta_valid_bit = 7;
    localparam int meta_dirty_bit = 6;  // never set, instruction side only

    // byte address as seen by the fetch port and the tag compare
    typedef union packed {
        logic [tag_bits+index_bits+offset_bits-1:0] raw;
        struct packed {
            logic [tag_bits-1:0]      tag;
            logic [index_bits-1:0]    index;
            logic [offset_bits-2:0]   word;
            logic                     byte_sel;
        } fields;
    } cache_addr_u;

endpackage

/* logic/data_array.sv */
module data_array
    import cache_pkg::*;
    import mem_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [word_bits-1:0]       data_in,
    input  logic                       write,
    input  logic [num_blocks-1:0]      block_enable,
    input  logic [words_per_block-1:0] word_enable,
    output logic [word_bits-1:0]       data_out
);

    localparam int block_bits = $clog2(num_blocks);
    localparam int word_sel_bits = $clog2(words_per_block);

    logic [word_bits-1:0] mem [num_blocks][words_per_block];
    logic [block_bits-1:0] block_sel;
    logic [word_sel_bits-1:0] word_sel;
    logic any_enable;

    // one-hot enables to array indices
    always_comb begin
        block_sel = '0;
        word_sel = '0;
        for (int b = 0; b < num_blocks; b++) begin
            if (block_enable[b]) begin
                block_sel = block_bits'(b);
            end
        end
        for (int w = 0; w < words_per_block; w++) begin
            if (word_enable[w]) begin
                word_sel = word_sel_bits'(w);
            end
        end
    end

    assign any_enable = (|block_enable) && (|word_enable);

    always_ff @(posedge clk) begin
        if (write && any_enable && !rst) begin  // writes held off during reset
            mem[block_sel][word_sel] <= data_in;
        end
    end

    assign data_out = any_enable ? mem[block_sel][word_sel] : '0;

endmodule

/* logic/fill_counter.sv */
module fill_counter
    import cache_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               start,
    input  logic                               issue,
    input  logic                               mem_valid,
    output logic [$clog2(words_per_block)-1:0] issue_count,
    output logic [$clog2(words_per_block)-1:0] recv_count,
    output logic                               issue_done,
    output logic                               fill_done
);

    localparam int cnt_bits = $clog2(words_per_block);
    localparam logic [cnt_bits-1:0] last_word = cnt_bits'(words_per_block - 1);

    always_ff @(posedge clk) begin
        if (rst || start) begin
            issue_count <= '0;
            recv_count <= '0;
            issue_done <= 1'b0;
        end else begin
            if (issue) begin
                issue_count <= issue_count + 1'b1;
                if (issue_count == last_word) begin
                    issue_done <= 1'b1;  // stays up until the next start
                end
            end
            if (mem_valid) begin
                recv_count <= recv_count + 1'b1;
            end
        end
    end

    // pulses with the last word of the block
    assign fill_done = mem_valid && (recv_count == last_word);

endmodule

/* logic/fill_fsm.sv */
module fill_fsm
    import cache_pkg::*;
    import mem_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               fetch_req,
    input  cache_addr_u                        fetch_addr,
    output cache_addr_u                        lookup_addr,
    output logic                               read_en,
    output logic                               write_en,
    output logic                               write_tag_en,
    output logic [num_blocks-1:0]              ext_block_enable,
    output logic [words_per_block-1:0]         ext_word_enable,
    input  logic                               hit,
    input  logic                               miss,
    input  logic [word_bits-1:0]               cache_data,
    output logic                               start,
    output logic                               issue,
    input  logic [$clog2(words_per_block)-1:0] issue_count,
    input  logic [$clog2(words_per_block)-1:0] recv_count,
    input  logic                               issue_done,
    input  logic                               fill_done,
    output logic                               mem_req,
    output logic [word_bits-1:0]               mem_addr,
    input  logic                               mem_valid,
    output logic [word_bits-1:0]               fetch_data,
    output logic                               fetch_hit,
    output logic                               fetch_valid,
    output logic                               busy
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_fill = 2'd1;
    localparam logic [1:0] st_tag_write = 2'd2;
    localparam logic [1:0] st_replay = 2'd3;

    logic [1:0] state;
    cache_addr_u fill_addr;
    logic victim_way;
    logic [num_sets-1:0] victim_bits;  // round-robin pointer per set
    logic accept_hit;
    logic accept_miss;

    assign accept_hit = (state == st_idle) && fetch_req && hit;
    assign accept_miss = (state == st_idle) && miss;

    assign lookup_addr = (state == st_idle) ? fetch_addr : fill_addr;
    assign read_en = (state == st_idle) ? fetch_req : (state == st_replay);
    assign busy = (state != st_idle);

    assign start = accept_miss;
    assign issue = (state == st_fill) && !issue_done;
    assign mem_req = issue;
    // block base word address plus the request number
    assign mem_addr = word_bits'({fill_addr.raw[$bits(cache_addr_u)-1:offset_bits],
                                  issue_count});

    // tag write also raises write_en so only the victim way is enabled
    assign write_en = ((state == st_fill) && mem_valid) || (state == st_tag_write);
    assign write_tag_en = (state == st_tag_write);
    assign ext_block_enable = num_blocks'(1) << {fill_addr.fields.index, victim_way};
    assign ext_word_enable = (state == st_fill) ? (words_per_block'(1) << recv_count) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            victim_bits <= '0;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept_miss) begin
                        state <= st_fill;
                        victim_bits[fetch_addr.fields.index] <=
                            !victim_bits[fetch_addr.fields.index];
                    end else if (accept_hit) begin
                        fetch_valid <= 1'b1;
                    end
                end
                st_fill: begin
                    if (fill_done) begin
                        state <= st_tag_write;
                    end
                end
                st_tag_write: state <= st_replay;
                st_replay: begin
                    state <= st_idle;
                    fetch_valid <= 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept_miss) begin
            fill_addr <= fetch_addr;
            victim_way <= victim_bits[fetch_addr.fields.index];
        end
        if (accept_hit || (state == st_replay)) begin
            fetch_data <= cache_data;
            fetch_hit <= accept_hit;  // replay result counts as a miss
        end
    end

endmodule

/* logic/i_cache.sv */
module i_cache
    import cache_pkg::*;
    import mem_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  cache_addr_u                addr,
    input  logic [word_bits-1:0]       data_in,
    input  logic                       write_en,
    input  logic                       read_en,
    input  logic                       write_tag_en,
    input  logic [num_blocks-1:0]      ext_block_enable,
    input  logic [words_per_block-1:0] ext_word_enable,
    output logic [word_bits-1:0]       data_out,
    output logic                       hit,
    output logic                       miss
);

    logic [words_per_block-1:0] word_enable;
    logic [num_blocks-1:0] block_enable [2];
    logic [word_bits-1:0] way_data [2];
    logic [meta_valid_bit:0] way_meta [2];
    logic [meta_valid_bit:0] meta_in;
    logic [1:0] way_hit;
    logic [word_bits-1:0] selected_data;

    assign word_enable = write_en ? ext_word_enable
                                  : words_per_block'(1) << addr.fields.word;

    always_comb begin
        meta_in = '0;
        meta_in[meta_valid_bit] = 1'b1;
        meta_in[meta_dirty_bit] = 1'b0;
        meta_in[tag_bits-1:0] = addr.fields.tag;
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign block_enable[w] = write_en ? ext_block_enable
                                          : num_blocks'(1) << {addr.fields.index, 1'(w)};

        data_array i_data (
            .clk          (clk),
            .rst          (rst),
            .data_in      (data_in),
            .write        (write_en),
            .block_enable (block_enable[w]),
            .word_enable  (word_enable),
            .data_out     (way_data[w])
        );

        meta_array i_meta (
            .clk          (clk),
            .rst          (rst),
            .data_in      (meta_in),
            .write        (write_tag_en),
            .block_enable (block_enable[w]),
            .data_out     (way_meta[w])
        );

        assign way_hit[w] = way_meta[w][meta_valid_bit]
                            && (way_meta[w][tag_bits-1:0] == addr.fields.tag);
    end

    assign selected_data = way_hit[0] ? way_data[0] : way_data[1];

    assign hit = |way_hit;
    assign miss = read_en && !hit;
    assign data_out = (read_en && hit) ? selected_data : '0;

endmodule

/* logic/icache_top.sv */
module icache_top
    import cache_pkg::*;
    import mem_pkg::*;
#(
    parameter int mem_latency = 3,
    parameter int mem_words = 4096
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch_req,
    input  cache_addr_u          fetch_addr,
    output logic [word_bits-1:0] fetch_data,
    output logic                 fetch_valid,
    output logic                 fetch_hit,
    output logic                 busy
);

    cache_addr_u lookup_addr;
    logic read_en;
    logic write_en;
    logic write_tag_en;
    logic [num_blocks-1:0] ext_block_enable;
    logic [words_per_block-1:0] ext_word_enable;
    logic hit;
    logic miss;
    logic [word_bits-1:0] cache_data;
    logic start;
    logic issue;
    logic [$clog2(words_per_block)-1:0] issue_count;
    logic [$clog2(words_per_block)-1:0] recv_count;
    logic issue_done;
    logic fill_done;
    logic mem_req;
    logic [word_bits-1:0] mem_addr;
    logic mem_valid;
    logic [word_bits-1:0] mem_rdata;

    i_cache i_icache (
        .clk              (clk),
        .rst              (rst),
        .addr             (lookup_addr),
        .data_in          (mem_rdata),  // refill words go straight in
        .write_en         (write_en),
        .read_en          (read_en),
        .write_tag_en     (write_tag_en),
        .ext_block_enable (ext_block_enable),
        .ext_word_enable  (ext_word_enable),
        .data_out         (cache_data),
        .hit              (hit),
        .miss             (miss)
    );

    fill_fsm i_fill_fsm (
        .clk              (clk),
        .rst              (rst),
        .fetch_req        (fetch_req),
        .fetch_addr       (fetch_addr),
        .lookup_addr      (lookup_addr),
        .read_en          (read_en),
        .write_en         (write_en),
        .write_tag_en     (write_tag_en),
        .ext_block_enable (ext_block_enable),
        .ext_word_enable  (ext_word_enable),
        .hit              (hit),
        .miss             (miss),
        .cache_data       (cache_data),
        .start            (start),
        .issue            (issue),
        .issue_count      (issue_count),
        .recv_count       (recv_count),
        .issue_done       (issue_done),
        .fill_done        (fill_done),
        .mem_req          (mem_req),
        .mem_addr         (mem_addr),
        .mem_valid        (mem_valid),
        .fetch_data       (fetch_data),
        .fetch_hit        (fetch_hit),
        .fetch_valid      (fetch_valid),
        .busy             (busy)
    );

    fill_counter i_fill_counter (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .issue       (issue),
        .mem_valid   (mem_valid),
        .issue_count (issue_count),
        .recv_count  (recv_count),
        .issue_done  (issue_done),
        .fill_done   (fill_done)
    );

    main_memory #(
        .mem_latency (mem_latency),
        .mem_words   (mem_words)
    ) i_main_memory (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_rdata (mem_rdata)
    );

endmodule

/* logic/main_memory.sv */
module main_memory
    import mem_pkg::*;
#(
    parameter int mem_latency = 3,
    parameter int mem_words = 4096
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem_req,
    input  logic [word_bits-1:0] mem_addr,
    output logic                 mem_valid,
    output logic [word_bits-1:0] mem_rdata
);

    logic [word_bits-1:0] mem [mem_words];
    logic [mem_latency-1:0] valid_pipe;
    logic [word_bits-1:0] data_pipe [mem_latency];

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = mem_pattern(word_bits'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= mem_req;
            for (int s = 1; s < mem_latency; s++) begin
                valid_pipe[s] <= valid_pipe[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[mem_addr % mem_words];  // address wraps
        for (int s = 1; s < mem_latency; s++) begin
            data_pipe[s] <= data_pipe[s-1];
        end
    end

    assign mem_valid = valid_pipe[mem_latency-1];
    assign mem_rdata = data_pipe[mem_latency-1];

endmodule

/* logic/mem_pkg.sv */
package mem_pkg;

    localparam int word_bits = 16;

    // content of the backing memory at a given word address
    function automatic logic [word_bits-1:0] mem_pattern(
        input logic [word_bits-1:0] word_addr
    );
        return word_addr ^ 16'h5a3c;
    endfunction

endpackage

/* logic/meta_array.sv */
module meta_array
    import cache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [meta_valid_bit:0]   data_in,
    input  logic                      write,
    input  logic [num_blocks-1:0]     block_enable,
    output logic [meta_valid_bit:0]   data_out
);

    localparam int block_bits = $clog2(num_blocks);

    logic [meta_valid_bit:0] meta [num_blocks];
    logic [block_bits-1:0] block_sel;

    always_comb begin
        block_sel = '0;
        for (int b = 0; b < num_blocks; b++) begin
            if (block_enable[b]) begin
                block_sel = block_bits'(b);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int b = 0; b < num_blocks; b++) begin
                meta[b] <= '0;  // every block starts invalid
            end
        end else if (write && (|block_enable)) begin
            meta[block_sel] <= data_in;
        end
    end

    assign data_out = (|block_enable) ? meta[block_sel] : '0;

endmodule

/* project.f */
logic/cache_pkg.sv
logic/mem_pkg.sv
logic/data_array.sv
logic/meta_array.sv
logic/i_cache.sv
logic/fill_counter.sv
logic/fill_fsm.sv
logic/main_memory.sv
logic/icache_top.sv
verification/icache_tb.sv

/* verification/icache_tb.sv */
module icache_tb
    import cache_pkg::*;
    import mem_pkg::*;
();

    localparam int mem_latency = 3;
    localparam int mem_words = 4096;
    localparam int reset_cycles = 8;
    localparam int max_rows = 64;
    localparam int random_rows = 40;

    logic clk;
    logic rst;
    logic fetch_req;
    cache_addr_u fetch_addr;
    logic [word_bits-1:0] fetch_data;
    logic fetch_valid;
    logic fetch_hit;
    logic busy;

    // stimulus and expected results, one row per fetch
    logic [15:0] row_addr [max_rows];
    int row_delay [max_rows];
    logic row_hit [max_rows];
    logic [word_bits-1:0] row_data [max_rows];
    int num_rows;

    // reference model of the tag store and round-robin victims
    logic [tag_bits-1:0] model_tag [num_sets][2];
    logic model_valid [num_sets][2];
    logic model_victim [num_sets];

    int error_count;
    int check_count;
    int cycle_count;
    int cycle_limit;

    icache_top #(
        .mem_latency (mem_latency),
        .mem_words   (mem_words)
    ) i_icache_top (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .fetch_valid (fetch_valid),
        .fetch_hit   (fetch_hit),
        .busy        (busy)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: fetches still pending after %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // predicts hit and data for one fetch, then updates the model
    task automatic add_row(input logic [15:0] addr, input int delay);
        logic [tag_bits-1:0] tag;
        logic [index_bits-1:0] set;
        logic hit;
        int way;
        tag = addr[15 -: tag_bits];
        set = addr[offset_bits +: index_bits];
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[set][w] && model_tag[set][w] == tag) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            way = model_victim[set];
            model_valid[set][way] = 1'b1;
            model_tag[set][way] = tag;
            model_victim[set] = !model_victim[set];
        end
        row_addr[num_rows] = addr;
        row_delay[num_rows] = delay;
        row_hit[num_rows] = hit;
        row_data[num_rows] = mem_pattern(word_bits'((addr >> 1) % mem_words));  // wraps
        num_rows++;
    endtask

    task automatic build_table();
        logic [15:0] addr;
        logic [15:0] last_addr;
        for (int s = 0; s < num_sets; s++) begin
            model_valid[s][0] = 1'b0;
            model_valid[s][1] = 1'b0;
            model_victim[s] = 1'b0;
        end
        add_row(16'h0124, 0);  // cold miss
        add_row(16'h0124, 0);
        for (int w = 0; w < words_per_block; w++) begin
            add_row(16'h0120 + 16'(2 * w), w % 4);  // rest of the block
        end
        add_row(16'h0125, 1);
        add_row(16'h0520, 2);  // same set, second tag
        add_row(16'h0124, 0);
        add_row(16'h052e, 3);
        add_row(16'h0920, 1);  // third tag takes the victim way
        add_row(16'h052a, 0);
        add_row(16'h0128, 2);
        last_addr = '0;
        for (int i = 0; i < random_rows; i++) begin
            if (i > 0 && i % 3 == 0) begin
                addr = {last_addr[15:4], 4'($urandom)};  // revisit a recent block
            end else begin
                addr = 16'($urandom);
            end
            add_row(addr, int'($urandom % 4));
            last_addr = addr;
        end
    endtask

    task automatic run_row(input int r);
        int latency;
        logic busy_after;
        repeat (row_delay[r]) @(negedge clk);
        while (busy) @(negedge clk);
        fetch_req = 1'b1;
        fetch_addr.raw = row_addr[r];
        @(negedge clk);
        fetch_req = 1'b0;
        latency = 1;
        busy_after = busy;
        while (!fetch_valid) begin
            @(negedge clk);
            latency++;
        end
        compare_value("fetch_hit", 32'(fetch_hit), 32'(row_hit[r]));
        compare_value("fetch_data", 32'(fetch_data), 32'(row_data[r]));
        compare_value("busy", 32'(busy_after), 32'(!row_hit[r]));
        if (row_hit[r]) begin
            compare_value("fetch_valid latency", latency, 1);
        end
    endtask

    initial begin
        void'($urandom(32'h9efde2f9));
        rst = 1'b1;
        fetch_req = 1'b0;
        fetch_addr = '0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        num_rows = 0;
        build_table();
        cycle_limit = 40 * num_rows + reset_cycles;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        compare_value("fetch_valid", 32'(fetch_valid), 0);
        compare_value("busy", 32'(busy), 0);
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        $display("%0d fetches, %0d checks, %0d errors", num_rows, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
